// File: bench/mpu_checker.sv
////////////////////////////////////////
// Result port checker
// Queues expected results, compares each transfer in order
// and watches that stalled results hold still
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module mpu_checker (
	input wire clock,
	input wire reset,
	// Watched result port
	input wire result_valid,
	input wire mpu_pkg::lane_id_t result_lane,
	input wire mpu_pkg::id_t result_thread_id,
	input wire mpu_pkg::issue_no_t result_issue_no,
	input wire mpu_pkg::instr_t result_signature,
	input wire result_ready,
	// Expected results from the testbench
	input wire exp_push,
	input wire mpu_pkg::lane_id_t exp_lane,
	input wire mpu_pkg::id_t exp_thread_id,
	input wire mpu_pkg::issue_no_t exp_issue_no,
	input wire mpu_pkg::instr_t exp_signature,
	output int pending,
	output int error_count,
	output int results_checked
);

	typedef struct packed {
		mpu_pkg::lane_id_t lane;
		mpu_pkg::id_t thread_id;
		mpu_pkg::issue_no_t issue_no;
		mpu_pkg::instr_t signature;
	} result_t;

	result_t exp_q[$];
	result_t want;
	result_t seen;
	result_t held_word; // Fields seen while stalled
	logic held;

	initial begin
		pending = 0;
		error_count = 0;
		results_checked = 0;
		held = 1'b0;
	end

	task automatic check_field(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			error_count++;
			$display("Mismatch at %0t: %s expected %0h got %0h", $time, name, expected, actual);
		end
	endtask

	always @(posedge clock) begin
		seen = {result_lane, result_thread_id, result_issue_no, result_signature};
		if (exp_push) begin
			exp_q.push_back({exp_lane, exp_thread_id, exp_issue_no, exp_signature});
		end

		////////////////////////////////////////
		// Transfers, compared in order
		////////////////////////////////////////
		if (!reset && result_valid && result_ready) begin
			results_checked++;
			if (exp_q.size() == 0) begin
				error_count++;
				$display("Error at %0t: result from lane %0d arrived with nothing expected",
					$time, result_lane);
			end else begin
				want = exp_q.pop_front();
				check_field("result_lane", 32'(want.lane), 32'(seen.lane));
				check_field("result_thread_id", 32'(want.thread_id), 32'(seen.thread_id));
				check_field("result_issue_no", 32'(want.issue_no), 32'(seen.issue_no));
				check_field("result_signature", want.signature, seen.signature);
			end
		end

		// Stalled result must not move
		if (held) begin
			if (!result_valid) begin
				error_count++;
				$display("Error at %0t: result_valid dropped while result_ready was low", $time);
			end else begin
				check_field("held result_lane", 32'(held_word.lane), 32'(seen.lane));
				check_field("held result_thread_id", 32'(held_word.thread_id),
					32'(seen.thread_id));
				check_field("held result_issue_no", 32'(held_word.issue_no), 32'(seen.issue_no));
				check_field("held result_signature", held_word.signature, seen.signature);
			end
		end
		held = !reset && result_valid && !result_ready;
		held_word = seen;
		pending = exp_q.size();
	end

endmodule

`default_nettype wire

// File: bench/mpu_tb.sv
////////////////////////////////////////
// Top testbench of the thread dispatch block
// Fills the tables over APB, issues threads and hands the
// expected results to the checker
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none
`include "mpu_consts.svh"

module mpu_tb;

	logic clock;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`MPU_APB_ADDR_W-1:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic issue_req;
	mpu_pkg::id_t issue_thread_id;
	mpu_pkg::issue_no_t issue_no;
	logic issue_ready;
	logic result_valid;
	mpu_pkg::lane_id_t result_lane;
	mpu_pkg::id_t result_thread_id;
	mpu_pkg::issue_no_t result_issue_no;
	mpu_pkg::instr_t result_signature;
	logic result_ready;

	logic exp_push;
	mpu_pkg::lane_id_t exp_lane;
	mpu_pkg::id_t exp_thread_id;
	mpu_pkg::issue_no_t exp_issue_no;
	mpu_pkg::instr_t exp_signature;
	int pending;
	int checker_errors;
	int results_checked;

	// Shadow of what the host wrote
	mpu_pkg::instr_t shadow_prog [`MPU_IMEM_DEPTH];
	mpu_pkg::mpu_address_t shadow_base [`MPU_THREADS];
	mpu_pkg::length_t shadow_len [`MPU_THREADS];

	logic [31:0] lfsr_state = 32'hb0da;
	logic random_ready = 1'b0;
	mpu_pkg::issue_no_t issue_count = 8'h10;
	int cycle_budget = 4 * (2 * 3 * (`MPU_IMEM_DEPTH + `MPU_THREADS)) + 100;
	int tb_errors = 0;
	int errors_before = 0;
	int tests_run = 0;
	int tests_failed = 0;

	tb_clock tb_clock_i (.clock, .reset);

	mpu_dispatch_top mpu_dispatch_top_i (
		.clock, .reset,
		.psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
		.issue_req, .issue_thread_id, .issue_no, .issue_ready,
		.result_valid, .result_lane, .result_thread_id, .result_issue_no,
		.result_signature, .result_ready
	);

	mpu_checker mpu_checker_i (
		.clock, .reset,
		.result_valid, .result_lane, .result_thread_id, .result_issue_no,
		.result_signature, .result_ready,
		.exp_push, .exp_lane, .exp_thread_id, .exp_issue_no, .exp_signature,
		.pending, .error_count(checker_errors), .results_checked
	);

	////////////////////////////////////////
	// Random source and reference model
	////////////////////////////////////////
	function automatic logic [31:0] take_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
		end
		return value;
	endfunction

	// Sum of the thread's words, each XORed with the lane byte pattern
	function automatic mpu_pkg::instr_t expected_signature(input mpu_pkg::id_t thread,
		input int lane);
		mpu_pkg::instr_t sum;
		mpu_pkg::instr_t pattern;
		mpu_pkg::mpu_address_t address;
		sum = '0;
		pattern = {4{8'(lane)}};
		address = shadow_base[thread];
		for (int i = 0; i < int'(shadow_len[thread]); i++) begin
			sum = sum + (shadow_prog[address] ^ pattern);
			address = address + 8'd1; // Wraps with the memory
		end
		return sum;
	endfunction

	////////////////////////////////////////
	// Bus and issue tasks run from a falling edge
	////////////////////////////////////////
	task automatic apb_write(input logic [`MPU_APB_ADDR_W-1:0] addr, input logic [31:0] data);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(negedge clock);
		penable = 1'b1;
		@(negedge clock);
		if (pready !== 1'b1) report_mismatch("pready", 32'd1, 32'(pready));
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input logic [`MPU_APB_ADDR_W-1:0] addr, output logic [31:0] data);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(negedge clock);
		penable = 1'b1;
		@(negedge clock);
		if (pready !== 1'b1) report_mismatch("pready", 32'd1, 32'(pready));
		data = prdata; // Registered on the setup cycle
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		tb_errors++;
		$display("Mismatch at %0t: %s expected %0h got %0h", $time, name, expected, actual);
	endtask

	task automatic push_expected(input mpu_pkg::id_t thread, input mpu_pkg::issue_no_t number);
		for (int lane = 0; lane < `MPU_LANES; lane++) begin
			exp_push = 1'b1;
			exp_lane = mpu_pkg::lane_id_t'(lane);
			exp_thread_id = thread;
			exp_issue_no = number;
			exp_signature = expected_signature(thread, lane);
			@(negedge clock);
		end
		exp_push = 1'b0;
	endtask

	// Leaves issue_req high for the caller to drop
	task automatic issue_thread(input mpu_pkg::id_t thread, input mpu_pkg::issue_no_t number);
		issue_req = 1'b1;
		issue_thread_id = thread;
		issue_no = number;
		while (!issue_ready) @(negedge clock);
		@(negedge clock); // Taken on the edge just passed
		if (issue_ready !== 1'b0) begin
			tb_errors++;
			$display("Error at %0t: issue_ready still high after thread %0d was taken",
				$time, thread);
		end
	endtask

	task automatic wait_results;
		while (pending != 0) @(negedge clock);
	endtask

	task automatic run_thread(input mpu_pkg::id_t thread);
		push_expected(thread, issue_count);
		issue_thread(thread, issue_count);
		issue_req = 1'b0;
		issue_count++;
		wait_results();
	endtask

	task automatic start_test;
		errors_before = tb_errors + checker_errors;
	endtask

	task automatic finish_test(input int number, input string name);
		int errs;
		errs = tb_errors + checker_errors - errors_before;
		tests_run++;
		if (errs == 0) begin
			$display("Test %0d %s: ok", number, name);
		end else begin
			tests_failed++;
			$display("Test %0d %s: failed with %0d errors", number, name, errs);
		end
	endtask

	task automatic fill_tables;
		int instr_cycles;
		instr_cycles = 0;
		for (int i = 0; i < `MPU_IMEM_DEPTH; i++) begin
			shadow_prog[i] = take_bits(32);
			apb_write(`MPU_APB_ADDR_W'(4 * i), shadow_prog[i]);
		end
		for (int t = 0; t < `MPU_THREADS; t++) begin
			shadow_base[t] = 8'(take_bits(8));
			shadow_len[t] = 8'(take_bits(5)) + 8'd1;
			if (t == 14) begin // Longest thread ending on the last word
				shadow_base[t] = 8'd1;
				shadow_len[t] = 8'd255;
			end else if (t == 15) begin
				shadow_base[t] = 8'd255;
				shadow_len[t] = 8'd1;
			end
			apb_write(`MPU_APB_ADDR_W'(`MPU_MAP_BASE + 4 * t),
				{16'h0000, shadow_len[t], shadow_base[t]});
			instr_cycles += int'(shadow_len[t]) + 16;
		end
		cycle_budget += 8 * instr_cycles; // Each thread runs at most twice with stalls
	endtask

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////
	initial begin
		result_ready = 1'b1;
		forever begin
			@(negedge clock);
			result_ready = random_ready ? take_bits(1) : 1'b1;
		end
	end

	initial begin
		logic [31:0] word;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		issue_req = 1'b0;
		issue_thread_id = '0;
		issue_no = '0;
		exp_push = 1'b0;
		exp_lane = '0;
		exp_thread_id = '0;
		exp_issue_no = '0;
		exp_signature = '0;
		@(posedge clock);
		while (reset) @(posedge clock);
		@(negedge clock);

		start_test();
		if (issue_ready !== 1'b1) report_mismatch("issue_ready", 32'd1, 32'(issue_ready));
		if (result_valid !== 1'b0) report_mismatch("result_valid", 32'd0, 32'(result_valid));
		finish_test(6, "reset state");

		fill_tables();

		start_test();
		for (int i = 0; i < `MPU_IMEM_DEPTH; i++) begin
			apb_read(`MPU_APB_ADDR_W'(4 * i), word);
			if (word !== shadow_prog[i]) report_mismatch("prdata", shadow_prog[i], word);
		end
		for (int t = 0; t < `MPU_THREADS; t++) begin
			apb_read(`MPU_APB_ADDR_W'(`MPU_MAP_BASE + 4 * t), word);
			if (word !== {16'h0000, shadow_len[t], shadow_base[t]}) begin
				report_mismatch("prdata", {16'h0000, shadow_len[t], shadow_base[t]}, word);
			end
		end
		finish_test(1, "APB readback");

		start_test();
		run_thread(4'd3);
		finish_test(2, "single thread");

		start_test();
		run_thread(4'd14); // 255 words up to the top of memory
		run_thread(4'd15); // One word at the very top
		finish_test(3, "lengths 1 and 255");

		start_test();
		random_ready = 1'b1;
		for (int t = 0; t < 6; t++) begin
			run_thread(mpu_pkg::id_t'(t));
		end
		random_ready = 1'b0;
		finish_test(4, "back-pressure");

		// Request stays high from one thread to the next
		start_test();
		for (int k = 0; k < 8; k++) begin
			push_expected(mpu_pkg::id_t'(6 + k), issue_count + 8'(k));
		end
		for (int k = 0; k < 8; k++) begin
			issue_thread(mpu_pkg::id_t'(6 + k), issue_count + 8'(k));
		end
		issue_req = 1'b0;
		issue_count += 8'd8;
		wait_results();
		finish_test(5, "back-to-back issues");

		$display("Tests run %0d, failed %0d, results checked %0d, errors %0d",
			tests_run, tests_failed, results_checked, tb_errors + checker_errors);
		if (tests_failed == 0 && tb_errors + checker_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	// Budget grows once the thread lengths are known
	initial begin
		int cycles;
		cycles = 0;
		while (cycles <= cycle_budget) begin
			@(posedge clock);
			cycles++;
		end
		$display("Watchdog: run still busy after %0d cycles, stopping", cycles);
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
////////////////////////////////////////
// Testbench clock and power-up reset
// Reset is held for a few cycles, then released
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 10,
	parameter int RESET_CYCLES = 4
) (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		reset = 1'b0; // Released away from the active edge
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+rtl
rtl/mpu_pkg.sv
rtl/thread_map_table.sv
rtl/dispatch_mpu.sv
rtl/tpu_lane.sv
rtl/commit_unit.sv
rtl/mpu_dispatch_top.sv
bench/tb_clock.sv
bench/mpu_checker.sv
bench/mpu_tb.sv

// File: rtl/commit_unit.sv
////////////////////////////////////////
// Commit unit
// Once every lane is done, hands out the lane results in
// lane order over a valid/ready port
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none
`include "mpu_consts.svh"

module commit_unit (
	input wire clock,
	input wire reset,
	input wire [`MPU_LANES-1:0] lane_done,
	input wire mpu_pkg::instr_t [`MPU_LANES-1:0] lane_signature,
	input wire mpu_pkg::id_t [`MPU_LANES-1:0] lane_thread_id,
	input wire mpu_pkg::issue_no_t [`MPU_LANES-1:0] lane_issue_no,
	output logic lane_clear,
	output logic commit_idle,
	// Result port
	output logic result_valid,
	output mpu_pkg::lane_id_t result_lane,
	output mpu_pkg::id_t result_thread_id,
	output mpu_pkg::issue_no_t result_issue_no,
	output mpu_pkg::instr_t result_signature,
	input wire result_ready
);

	logic presenting;
	mpu_pkg::lane_id_t lane_ptr;
	logic accept;
	logic last_accept;

	assign accept = presenting && result_ready;
	assign last_accept = accept && (lane_ptr == mpu_pkg::lane_id_t'(`MPU_LANES - 1));

	// Lanes release their results on the final transfer
	assign lane_clear = last_accept;
	assign commit_idle = last_accept;

	always_ff @(posedge clock) begin
		if (reset) begin
			presenting <= 1'b0;
			lane_ptr <= '0;
		end else if (!presenting) begin
			if (&lane_done) begin
				presenting <= 1'b1;
				lane_ptr <= '0;
			end
		end else if (accept) begin
			if (last_accept) begin
				presenting <= 1'b0;
			end else begin
				lane_ptr <= lane_ptr + 1'b1;
			end
		end
	end

	// Lane registers hold still until cleared
	assign result_valid = presenting;
	assign result_lane = lane_ptr;
	assign result_thread_id = lane_thread_id[lane_ptr];
	assign result_issue_no = lane_issue_no[lane_ptr];
	assign result_signature = lane_signature[lane_ptr];

	result_hold_a: assert property (@(posedge clock) disable iff (reset)
		result_valid && !result_ready |=> result_valid && $stable(result_lane) &&
			$stable(result_thread_id) && $stable(result_issue_no) &&
			$stable(result_signature))
		else $error("commit_unit: result changed while stalled");

endmodule

`default_nettype wire

// File: rtl/dispatch_mpu.sv
////////////////////////////////////////
// Thread dispatcher
// Takes an issue, looks the thread up, then broadcasts
// ID, issue number, length and the instructions to lanes
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module dispatch_mpu (
	input wire clock,
	input wire reset,
	// Issue port
	input wire issue_req,
	input wire mpu_pkg::id_t issue_thread_id,
	input wire mpu_pkg::issue_no_t issue_no,
	output logic issue_ready,
	// Map lookup
	output logic lookup_req,
	output mpu_pkg::id_t lookup_id,
	input wire lookup_ack,
	input wire mpu_pkg::mpu_address_t lookup_base,
	input wire mpu_pkg::length_t lookup_length,
	// Instruction load
	output logic ld,
	output mpu_pkg::mpu_address_t ld_address,
	input wire mpu_pkg::instr_t instr_data,
	// Broadcast to lanes
	output logic stream_valid,
	output mpu_pkg::instr_t stream_word,
	input wire commit_idle
);

	mpu_pkg::fsm_dispatch_t state;

	mpu_pkg::id_t thread_id;
	mpu_pkg::issue_no_t thread_issue_no;
	mpu_pkg::length_t thread_length;
	mpu_pkg::length_t remaining; // Loads still to issue
	logic ld_d1;                 // instr_data valid
	logic accept;
	logic sending_header;

	assign accept = issue_req && issue_ready;
	assign issue_ready = state == mpu_pkg::IDLE;
	assign lookup_req = state == mpu_pkg::GETINFO; // Held until ack
	assign lookup_id = thread_id;
	assign ld = state == mpu_pkg::SEND_INSTRS;
	assign sending_header = (state == mpu_pkg::SEND_THREADID) ||
		(state == mpu_pkg::SEND_ISSUENO) || (state == mpu_pkg::SEND_ILENGTH);

	////////////////////////////////////////
	// Thread context and load counters
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (accept) begin
			thread_id <= issue_thread_id;
			thread_issue_no <= issue_no;
		end
		if (lookup_ack) begin
			thread_length <= lookup_length;
			remaining <= lookup_length;
			ld_address <= lookup_base;
		end else if (ld) begin
			remaining <= remaining - 1'b1;
			ld_address <= ld_address + 1'b1; // Wraps at top of memory
		end
	end

	////////////////////////////////////////
	// Broadcast stream
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			ld_d1 <= 1'b0;
			stream_valid <= 1'b0;
		end else begin
			ld_d1 <= ld;
			stream_valid <= sending_header || ld_d1;
		end
	end

	always_ff @(posedge clock) begin
		case (state)
			mpu_pkg::SEND_THREADID: stream_word <= {28'h0, thread_id};
			mpu_pkg::SEND_ISSUENO: stream_word <= {24'h0, thread_issue_no};
			mpu_pkg::SEND_ILENGTH: stream_word <= {24'h0, thread_length};
			default: stream_word <= instr_data;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= mpu_pkg::IDLE;
		end else begin
			case (state)
				mpu_pkg::IDLE: if (accept) state <= mpu_pkg::GETINFO;
				mpu_pkg::GETINFO: if (lookup_ack) state <= mpu_pkg::SEND_THREADID;
				mpu_pkg::SEND_THREADID: state <= mpu_pkg::SEND_ISSUENO;
				mpu_pkg::SEND_ISSUENO: state <= mpu_pkg::SEND_ILENGTH;
				mpu_pkg::SEND_ILENGTH: state <= mpu_pkg::SEND_INSTRS;
				mpu_pkg::SEND_INSTRS: begin
					if (remaining == 8'd1) begin // Last load this cycle
						state <= mpu_pkg::WAIT_COMMIT;
					end
				end
				mpu_pkg::WAIT_COMMIT: if (commit_idle) state <= mpu_pkg::IDLE;
				default: state <= mpu_pkg::IDLE;
			endcase
		end
	end

	// A zero length would run the load counter through zero
	ld_remaining_a: assert property (@(posedge clock) disable iff (reset)
		ld |-> remaining != '0)
		else $error("dispatch_mpu: load with no instructions left");

	// Map table acks only the pending lookup
	ack_in_getinfo_a: assert property (@(posedge clock) disable iff (reset)
		lookup_ack |-> state == mpu_pkg::GETINFO)
		else $error("dispatch_mpu: lookup ack outside GETINFO");

endmodule

`default_nettype wire

// File: rtl/mpu_consts.svh
////////////////////////////////////////
// Sizes and APB address map of the dispatch block
// Include wherever lane count, memory depth or the map
// layout is needed
////////////////////////////////////////
`ifndef MPU_CONSTS_SVH
`define MPU_CONSTS_SVH

// Processing lanes fed by the dispatcher
`define MPU_LANES 4

// Program memory words
`define MPU_IMEM_DEPTH 256

// Thread map table entries
`define MPU_THREADS 16

// APB byte address width and start of the map table
`define MPU_APB_ADDR_W 12
`define MPU_MAP_BASE 12'h400

`endif

// File: rtl/mpu_dispatch_top.sv
////////////////////////////////////////
// Top of the thread dispatch block
// APB fills the tables, the issue port starts a thread,
// results leave through the commit port
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none
`include "mpu_consts.svh"

module mpu_dispatch_top (
	input wire clock,
	input wire reset,
	// APB
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [`MPU_APB_ADDR_W-1:0] paddr,
	input wire [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	// Issue
	input wire issue_req,
	input wire mpu_pkg::id_t issue_thread_id,
	input wire mpu_pkg::issue_no_t issue_no,
	output logic issue_ready,
	// Results
	output logic result_valid,
	output mpu_pkg::lane_id_t result_lane,
	output mpu_pkg::id_t result_thread_id,
	output mpu_pkg::issue_no_t result_issue_no,
	output mpu_pkg::instr_t result_signature,
	input wire result_ready
);

	logic lookup_req;
	mpu_pkg::id_t lookup_id;
	logic lookup_ack;
	mpu_pkg::mpu_address_t lookup_base;
	mpu_pkg::length_t lookup_length;
	logic ld;
	mpu_pkg::mpu_address_t ld_address;
	mpu_pkg::instr_t instr_data;
	logic stream_valid;
	mpu_pkg::instr_t stream_word;
	logic commit_idle;
	logic lane_clear;

	logic [`MPU_LANES-1:0] lane_done;
	mpu_pkg::instr_t [`MPU_LANES-1:0] lane_signature;
	mpu_pkg::id_t [`MPU_LANES-1:0] lane_thread_id;
	mpu_pkg::issue_no_t [`MPU_LANES-1:0] lane_issue_no;

	thread_map_table thread_map_table_i (
		.clock, .reset,
		.psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
		.lookup_req, .lookup_id, .lookup_ack, .lookup_base, .lookup_length,
		.ld, .ld_address, .instr_data
	);

	dispatch_mpu dispatch_mpu_i (
		.clock, .reset,
		.issue_req, .issue_thread_id, .issue_no, .issue_ready,
		.lookup_req, .lookup_id, .lookup_ack, .lookup_base, .lookup_length,
		.ld, .ld_address, .instr_data,
		.stream_valid, .stream_word, .commit_idle
	);

	////////////////////////////////////////
	// Lanes, all fed the same stream
	////////////////////////////////////////
	for (genvar g = 0; g < `MPU_LANES; g++) begin : gen_lane
		tpu_lane #(.LANE(g)) tpu_lane_i (
			.clock, .reset,
			.stream_valid, .stream_word,
			.lane_done(lane_done[g]),
			.lane_signature(lane_signature[g]),
			.lane_thread_id(lane_thread_id[g]),
			.lane_issue_no(lane_issue_no[g]),
			.lane_clear
		);
	end

	commit_unit commit_unit_i (
		.clock, .reset,
		.lane_done, .lane_signature, .lane_thread_id, .lane_issue_no,
		.lane_clear, .commit_idle,
		.result_valid, .result_lane, .result_thread_id, .result_issue_no,
		.result_signature, .result_ready
	);

endmodule

`default_nettype wire

// File: rtl/mpu_pkg.sv
////////////////////////////////////////
// Shared types of the dispatch block
// Referenced by scoped name from every RTL module
////////////////////////////////////////
`default_nettype none

package mpu_pkg;

	// Instruction and stream word
	typedef logic [31:0] instr_t;

	typedef logic [3:0] id_t;          // Thread ID
	typedef logic [7:0] issue_no_t;    // Issue number from the scalar side
	typedef logic [7:0] mpu_address_t; // Program memory word address
	typedef logic [7:0] length_t;      // Instruction count, 1 to 255
	typedef logic [1:0] lane_id_t;     // Lane index

	// Dispatcher FSM
	typedef enum logic [2:0] {
		IDLE,
		GETINFO,
		SEND_THREADID,
		SEND_ISSUENO,
		SEND_ILENGTH,
		SEND_INSTRS,
		WAIT_COMMIT
	} fsm_dispatch_t;

endpackage

`default_nettype wire

// File: rtl/thread_map_table.sv
////////////////////////////////////////
// APB slave with program memory and thread map table
// Host writes both before issuing; dispatcher reads map
// entries and instructions on its own ports
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none
`include "mpu_consts.svh"

module thread_map_table (
	input wire clock,
	input wire reset,
	// APB
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [`MPU_APB_ADDR_W-1:0] paddr,
	input wire [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	// Lookup from dispatcher
	input wire lookup_req,
	input wire mpu_pkg::id_t lookup_id,
	output logic lookup_ack,
	output mpu_pkg::mpu_address_t lookup_base,
	output mpu_pkg::length_t lookup_length,
	// Instruction load
	input wire ld,
	input wire mpu_pkg::mpu_address_t ld_address,
	output mpu_pkg::instr_t instr_data
);

	mpu_pkg::instr_t imem [`MPU_IMEM_DEPTH];
	mpu_pkg::mpu_address_t map_base [`MPU_THREADS];
	mpu_pkg::length_t map_length [`MPU_THREADS];

	logic is_prog;
	logic is_map;
	logic apb_write;
	logic apb_read;
	logic prog_write;
	mpu_pkg::mpu_address_t prog_index;
	mpu_pkg::id_t map_index;

	////////////////////////////////////////
	// APB decode
	////////////////////////////////////////
	assign is_prog = paddr < `MPU_MAP_BASE;
	assign is_map = (paddr >= `MPU_MAP_BASE) &&
		(paddr < `MPU_MAP_BASE + 4 * `MPU_THREADS);
	assign prog_index = mpu_pkg::mpu_address_t'(paddr >> 2);
	assign map_index = mpu_pkg::id_t'((paddr - `MPU_MAP_BASE) >> 2);

	assign apb_write = psel && penable && pwrite;  // Access cycle
	assign apb_read = psel && !penable && !pwrite; // Setup cycle, data ready on access
	assign prog_write = apb_write && is_prog;
	assign pready = 1'b1;

	always_ff @(posedge clock) begin
		if (prog_write) begin
			imem[prog_index] <= pwdata;
		end
		if (apb_write && is_map) begin
			map_base[map_index] <= pwdata[7:0];
			map_length[map_index] <= pwdata[15:8];
		end
	end

	always_ff @(posedge clock) begin
		if (apb_read) begin
			if (is_prog) begin
				prdata <= imem[prog_index];
			end else if (is_map) begin
				prdata <= {16'h0000, map_length[map_index], map_base[map_index]};
			end else begin
				prdata <= '0; // Unmapped
			end
		end
	end

	////////////////////////////////////////
	// Dispatcher read paths
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			lookup_ack <= 1'b0;
		end else begin
			lookup_ack <= lookup_req && !lookup_ack; // One ack per request
		end
	end

	always_ff @(posedge clock) begin
		lookup_base <= map_base[lookup_id];
		lookup_length <= map_length[lookup_id];
		if (ld) begin
			instr_data <= imem[ld_address];
		end
	end

	// Host must not rewrite the program while a thread is loading
	no_ld_during_write_a: assert property (@(posedge clock) disable iff (reset)
		!(ld && prog_write))
		else $error("thread_map_table: program write during instruction load");

endmodule

`default_nettype wire

// File: rtl/tpu_lane.sv
////////////////////////////////////////
// One processing lane
// Parses the broadcast stream and folds the instructions
// into a lane-dependent signature held until cleared
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module tpu_lane #(
	parameter int LANE = 0
) (
	input wire clock,
	input wire reset,
	input wire stream_valid,
	input wire mpu_pkg::instr_t stream_word,
	output logic lane_done,
	output mpu_pkg::instr_t lane_signature,
	output mpu_pkg::id_t lane_thread_id,
	output mpu_pkg::issue_no_t lane_issue_no,
	input wire lane_clear
);

	// Lane index repeated in every byte
	localparam mpu_pkg::instr_t lane_pattern = {4{8'(LANE)}};

	logic [1:0] word_phase; // 0 to 2 header words, 3 body
	mpu_pkg::length_t remaining;
	logic last_instr;

	assign last_instr = stream_valid && (word_phase == 2'd3) && (remaining == 8'd1);

	always_ff @(posedge clock) begin
		if (reset) begin
			word_phase <= 2'd0;
			lane_done <= 1'b0;
		end else begin
			if (stream_valid && word_phase != 2'd3) begin
				word_phase <= word_phase + 1'b1;
			end else if (last_instr) begin
				word_phase <= 2'd0; // Ready for next header
			end
			if (last_instr) begin
				lane_done <= 1'b1;
			end else if (lane_clear) begin
				lane_done <= 1'b0;
			end
		end
	end

	////////////////////////////////////////
	// Header capture and signature
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (stream_valid) begin
			case (word_phase)
				2'd0: begin
					lane_thread_id <= stream_word[3:0];
					lane_signature <= '0; // New thread
				end
				2'd1: lane_issue_no <= stream_word[7:0];
				2'd2: remaining <= stream_word[7:0];
				default: begin
					lane_signature <= lane_signature + (stream_word ^ lane_pattern);
					remaining <= remaining - 1'b1;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the dispatch block testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module mpu_tb -f project.f --Mdir obj_dir -o mpu_sim

./obj_dir/mpu_sim | tee sim.log

if grep -q "Result: FAILED" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
	echo "Simulation ended without a result line"
	exit 1
fi
echo "Simulation passed"
